// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = l2_cache_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/l2_cache_stim.txt ====
RM 00000040 00000000 00000040
RH 00000040 00000000 00000040
WM 00000140 11110140 00000000
RH 00000140 00000000 11110140
RM 00000240 00000000 00000240
RD 00000040 00000000 00000040
RM 00000140 00000000 11110140
WH 00000040 22220040 00000000
RH 00000040 00000000 22220040
RM 00000240 00000000 00000240
CH 00000014 00000000 00000000
RD 00000140 00000000 11110140
WM 000000a0 333300a0 00000000
WM 000001a0 444401a0 00000000
CH 00000000 00000000 00000000
WD 000002a0 555502a0 00000000
RD 000000a0 00000000 333300a0
RD 000001a0 00000000 444401a0
RH 000000a0 00000000 333300a0
RM 000002a0 00000000 555502a0
RM 00000000 00000000 00000000
RM 00001000 00000000 00001000
RH 00000000 00000000 00000000
RH 000002a0 00000000 555502a0

// ==== dv/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int CREDITS    = 1;
	localparam int TIMEOUT    = 200; // cycles per access.
	localparam int RESP_DELAY = 2;

	logic  clk = 1'b0;
	logic  arst_n;
	addr_t mem_address;
	logic  mem_read;
	logic  mem_write;
	line_t mem_wdata;
	line_t mem_rdata;
	logic  mem_resp;
	addr_t pmem_address;
	logic  pmem_read;
	logic  pmem_write;
	line_t pmem_wdata;
	line_t pmem_rdata  = '0;
	logic  pmem_resp   = 1'b0;
	logic  pmem_credit = 1'b0;

	int         seed         = 32'hfdf0_782a;
	line_t      mem [addr_t];
	line_t      written [addr_t]; // last line the cpu wrote.
	logic [7:0] trace [$];        // pmem requests in order.
	int         resp_wait    = 0;
	int         credit_wait  = 0;
	int         credit_hold  = 0; // fixed credit delay when nonzero.
	int         credits_left = CREDITS;
	int         model_errors = 0;

	l2_cache #(
		.PMEM_CREDITS (CREDITS)
	) i_l2_cache (
		.clk          (clk),
		.arst_n       (arst_n),
		.mem_address  (mem_address),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.mem_resp     (mem_resp),
		.pmem_address (pmem_address),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp),
		.pmem_credit  (pmem_credit)
	);

	initial begin
		forever begin
			#5 clk = ~clk;
		end
	end

	// word k of the line is seed + k.
	function automatic line_t expand_line(input logic [31:0] word);
		line_t result;
		for (int k = 0; k < LINE_W / 32; k++) begin
			result[32*k +: 32] = word + 32'(k);
		end
		return result;
	endfunction

	////////////////////////////////////////
	// physical memory model
	////////////////////////////////////////

	always @(posedge clk) begin
		pmem_resp   <= 1'b0;
		pmem_credit <= 1'b0;
		if (resp_wait > 0) begin
			resp_wait--;
			pmem_resp <= (resp_wait == 0);
		end
		if (credit_wait > 0) begin
			credit_wait--;
			pmem_credit <= (credit_wait == 0);
		end
		if (pmem_read || pmem_write) begin
			assert (credits_left > 0) else begin
				$display("%0t: pmem request issued with no credit left", $time);
				model_errors++;
			end
			credits_left--;
			resp_wait   = RESP_DELAY;
			credit_wait = (credit_hold != 0) ? credit_hold : 1 + ($random(seed) & 3);
			if (pmem_write) begin
				trace.push_back("W");
				assert (written.exists(pmem_address)) else begin
					$display("%0t: writeback of %h, a line never written", $time, pmem_address);
					model_errors++;
				end
				if (written.exists(pmem_address)) begin
					assert (pmem_wdata == written[pmem_address]) else begin
						$display("ERR %0t pmem_wdata exp %h got %h", $time,
							written[pmem_address], pmem_wdata);
						model_errors++;
					end
				end
				mem[pmem_address] = pmem_wdata;
			end else begin
				trace.push_back("R");
				assert (pmem_address == (mem_address & ~32'h1f)) else begin
					$display("ERR %0t pmem_address exp %h got %h", $time,
						mem_address & ~32'h1f, pmem_address);
					model_errors++;
				end
				pmem_rdata <= mem.exists(pmem_address) ? mem[pmem_address]
					: expand_line(pmem_address);
			end
		end
		if (pmem_credit) begin
			credits_left++;
		end
	end

	////////////////////////////////////////
	// stimulus and checks
	////////////////////////////////////////

	initial begin
		int          fd;
		int          t0;
		int          n;
		int          cycles;
		int          tests;
		int          failed;
		int          errors;
		int          err_before;
		bit          stop;
		bit          ok;
		logic [15:0] op;
		logic [31:0] addr;
		logic [31:0] wseed;
		logic [31:0] rseed;

		arst_n      = 1'b0;
		mem_address = '0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_wdata   = '0;
		tests       = 0;
		failed      = 0;
		errors      = 0;
		stop        = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		fd = $fopen("dv/l2_cache_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/l2_cache_stim.txt");
			errors++;
			stop = 1'b1;
		end
		while (!stop && $fscanf(fd, "%s %h %h %h\n", op, addr, wseed, rseed) == 4) begin
			@(posedge clk);
			if (op == "CH") begin
				credit_hold = int'(addr);
			end else begin
				tests++;
				t0         = trace.size();
				err_before = errors + model_errors;
				mem_address <= addr;
				mem_read    <= (op[15:8] == "R");
				mem_write   <= (op[15:8] == "W");
				mem_wdata   <= expand_line(wseed);
				cycles = 0;
				do begin
					@(posedge clk);
					cycles++;
				end while (!mem_resp && cycles < TIMEOUT);
				mem_read  <= 1'b0;
				mem_write <= 1'b0;
				if (!mem_resp) begin
					$display("timeout: no mem_resp within %0d cycles on test %0d", TIMEOUT, tests);
					errors++;
					stop = 1'b1;
				end else begin
					if (op[15:8] == "R") begin
						assert (mem_rdata == expand_line(rseed)) else begin
							$display("ERR %0t mem_rdata exp %h got %h", $time,
								expand_line(rseed), mem_rdata);
							errors++;
						end
					end else begin
						written[addr] = expand_line(wseed);
					end
					// request is sampled one edge after it is driven.
					if (op[7:0] == "H") begin
						assert (cycles == 3) else begin
							$display("ERR %0t hit_latency exp 3 got %0d", $time, cycles);
							errors++;
						end
					end
					n = trace.size() - t0;
					case (op[7:0])
						"H":     ok = (n == 0);
						"M":     ok = (n == 1) && (trace[t0] == "R");
						default: ok = (n == 2) && (trace[t0] == "W") && (trace[t0+1] == "R");
					endcase
					assert (ok) else begin
						$display("%0t: pmem traffic not as expected, %0d requests", $time, n);
						errors++;
					end
				end
				if (errors + model_errors != err_before) begin
					failed++;
				end
				$display("test %0d %s %h: %s", tests, op, addr,
					(errors + model_errors == err_before) ? "ok" : "failed");
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("tests run %0d, failed %0d, check errors %0d", tests, failed,
			errors + model_errors);
		if (tests > 0 && errors + model_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : l2_cache_tb

`default_nettype wire

// ==== sim.f ====
verilog/l2_cache_pkg.sv
verilog/pmem_pkg.sv
verilog/cache_ctrl_if.sv
verilog/cache_array.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache_control.sv
verilog/l2_cache.sv
dv/l2_cache_tb.sv

// ==== verilog/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
	parameter int  S_INDEX   = 3,
	parameter type payload_t = logic
) (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               load,
	input  wire logic               read,
	input  wire logic [S_INDEX-1:0] rindex,
	input  wire logic [S_INDEX-1:0] windex,
	input  wire payload_t           datain,
	output payload_t                dataout
);

	localparam int NUM_SETS = 2**S_INDEX;

	payload_t data [NUM_SETS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (read) begin
				dataout <= (load && (rindex == windex)) ? datain : data[rindex]; // write-through.
			end
			if (load) begin
				data[windex] <= datain;
			end
		end
	end

	a_load_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(load))
		else $error("cache_array: load is unknown");

endmodule : cache_array

`default_nettype wire

// ==== verilog/cache_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if;
	import l2_cache_pkg::*;
	import pmem_pkg::*;

	// strobes from control.
	logic [NUM_WAYS-1:0] load_data;
	logic [NUM_WAYS-1:0] load_tag;
	logic [NUM_WAYS-1:0] set_valid;
	logic [NUM_WAYS-1:0] set_dirty;
	logic [NUM_WAYS-1:0] clear_dirty;
	logic                load_lru;
	logic                read_data;
	logic                wdata_from_cpu; // line source for a data write.
	pmem_addr_sel_e      pmem_sel;

	// status from the datapath.
	logic hit;
	logic way0_hit;
	logic victim_dirty;
	logic lru_out; // way to evict next.

	modport ctrl (
		output load_data, load_tag, set_valid, set_dirty, clear_dirty,
		output load_lru, read_data, wdata_from_cpu, pmem_sel,
		input  hit, way0_hit, victim_dirty, lru_out
	);

	modport dp (
		input  load_data, load_tag, set_valid, set_dirty, clear_dirty,
		input  load_lru, read_data, wdata_from_cpu, pmem_sel,
		output hit, way0_hit, victim_dirty, lru_out
	);

endinterface : cache_ctrl_if

`default_nettype wire

// ==== verilog/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
	parameter int S_OFFSET     = 5,
	parameter int S_INDEX      = 3,
	parameter int PMEM_CREDITS = 1
) (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire l2_cache_pkg::addr_t mem_address,
	input  wire logic                mem_read,
	input  wire logic                mem_write,
	input  wire l2_cache_pkg::line_t mem_wdata,
	output l2_cache_pkg::line_t      mem_rdata,
	output logic                     mem_resp,
	output l2_cache_pkg::addr_t      pmem_address,
	output logic                     pmem_read,
	output logic                     pmem_write,
	output l2_cache_pkg::line_t      pmem_wdata,
	input  wire l2_cache_pkg::line_t pmem_rdata,
	input  wire logic                pmem_resp,
	input  wire logic                pmem_credit
);

	cache_ctrl_if i_ctrl_if ();

	l2_cache_control #(
		.PMEM_CREDITS (PMEM_CREDITS)
	) i_control (
		.clk         (clk),
		.arst_n      (arst_n),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_resp    (mem_resp),
		.pmem_read   (pmem_read),
		.pmem_write  (pmem_write),
		.pmem_resp   (pmem_resp),
		.pmem_credit (pmem_credit),
		.cif         (i_ctrl_if.ctrl)
	);

	l2_cache_datapath #(
		.S_OFFSET (S_OFFSET),
		.S_INDEX  (S_INDEX)
	) i_datapath (
		.clk          (clk),
		.arst_n       (arst_n),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.pmem_rdata   (pmem_rdata),
		.mem_rdata    (mem_rdata),
		.pmem_wdata   (pmem_wdata),
		.pmem_address (pmem_address),
		.cif          (i_ctrl_if.dp)
	);

endmodule : l2_cache

`default_nettype wire

// ==== verilog/l2_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control #(
	parameter int PMEM_CREDITS = 1
) (
	input  wire logic  clk,
	input  wire logic  arst_n,
	input  wire logic  mem_read,
	input  wire logic  mem_write,
	output logic       mem_resp,
	output logic       pmem_read,
	output logic       pmem_write,
	input  wire logic  pmem_resp,
	input  wire logic  pmem_credit,
	cache_ctrl_if.ctrl cif
);
	import pmem_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_compare,
		st_writeback,
		st_fill,
		st_done
	} state_e;

	state_e              state;
	state_e              state_next;
	logic [CREDIT_W-1:0] credits;
	logic                issued; // request out, waiting for pmem_resp.
	logic                can_issue;
	logic                issue;
	logic                hit_way;
	logic                victim;

	assign can_issue = !issued && (credits != '0);
	assign issue     = pmem_read | pmem_write;
	assign hit_way   = ~cif.way0_hit;
	assign victim    = cif.lru_out;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_idle;
			issued  <= 1'b0;
			credits <= CREDIT_W'(PMEM_CREDITS);
		end else begin
			state <= state_next;
			if (issue) begin
				issued <= 1'b1;
			end else if (pmem_resp) begin
				issued <= 1'b0;
			end
			unique case ({pmem_credit, issue})
				2'b10:   credits <= credits + CREDIT_W'(1);
				2'b01:   credits <= credits - CREDIT_W'(1);
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////
	// next state and strobes
	////////////////////////////////////////

	always_comb begin
		state_next         = state;
		mem_resp           = 1'b0;
		pmem_read          = 1'b0;
		pmem_write         = 1'b0;
		cif.load_data      = '0;
		cif.load_tag       = '0;
		cif.set_valid      = '0;
		cif.set_dirty      = '0;
		cif.clear_dirty    = '0;
		cif.load_lru       = 1'b0;
		cif.read_data      = 1'b0;
		cif.wdata_from_cpu = 1'b0;
		cif.pmem_sel       = mem_addr;

		unique case (state)
			st_idle: begin
				if (mem_read || mem_write) begin
					cif.read_data = 1'b1; // arrays valid in compare.
					state_next    = st_compare;
				end
			end
			st_compare: begin
				if (cif.hit) begin
					cif.load_lru = 1'b1;
					if (mem_write) begin
						cif.wdata_from_cpu     = 1'b1;
						cif.load_data[hit_way] = 1'b1;
						cif.set_dirty[hit_way] = 1'b1;
					end
					state_next = st_done;
				end else begin
					state_next = cif.victim_dirty ? st_writeback : st_fill;
				end
			end
			st_writeback: begin
				cif.pmem_sel = victim ? way1_wb : way0_wb;
				pmem_write   = can_issue;
				if (issued && pmem_resp) begin
					state_next = st_fill;
				end
			end
			st_fill: begin
				pmem_read = can_issue;
				if (issued && pmem_resp) begin
					cif.wdata_from_cpu      = mem_write;
					cif.load_data[victim]   = 1'b1;
					cif.load_tag[victim]    = 1'b1;
					cif.set_valid[victim]   = 1'b1;
					cif.set_dirty[victim]   = mem_write;
					cif.clear_dirty[victim] = !mem_write;
					cif.load_lru            = 1'b1;
					cif.read_data           = 1'b1; // new line hits in done.
					state_next              = st_done;
				end
			end
			st_done: begin
				mem_resp   = 1'b1;
				state_next = st_idle;
			end
			default: state_next = st_idle;
		endcase
	end

	a_credit_on_issue: assert property (@(posedge clk) disable iff (!arst_n)
		(pmem_read || pmem_write) |-> (credits != '0))
		else $error("l2_cache_control: pmem request with no credit");

	// memory never returns more credits than it was given.
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= CREDIT_W'(PMEM_CREDITS))
		else $error("l2_cache_control: credit count above limit");

endmodule : l2_cache_control

`default_nettype wire

// ==== verilog/l2_cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath #(
	parameter int S_OFFSET = 5,
	parameter int S_INDEX  = 3
) (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire l2_cache_pkg::addr_t mem_address,
	input  wire l2_cache_pkg::line_t mem_wdata,
	input  wire l2_cache_pkg::line_t pmem_rdata,
	output l2_cache_pkg::line_t      mem_rdata,
	output l2_cache_pkg::line_t      pmem_wdata,
	output l2_cache_pkg::addr_t      pmem_address,
	cache_ctrl_if.dp                 cif
);
	import l2_cache_pkg::*;
	import pmem_pkg::*;

	localparam int S_TAG = ADDR_W - S_OFFSET - S_INDEX;

	logic [S_TAG-1:0]    tag_in;
	logic [S_INDEX-1:0]  index;
	line_t               line_in;
	line_t               data_out [NUM_WAYS];
	logic [S_TAG-1:0]    tag_out  [NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_out;
	logic [NUM_WAYS-1:0] dirty_out;
	logic [NUM_WAYS-1:0] way_hit;
	logic                lru_in;

	assign index   = mem_address[S_OFFSET +: S_INDEX];
	assign tag_in  = mem_address[ADDR_W-1 -: S_TAG];
	assign line_in = cif.wdata_from_cpu ? mem_wdata : pmem_rdata;
	assign lru_in  = cif.hit ? cif.way0_hit : ~cif.lru_out; // point away from the way used.

	////////////////////////////////////////
	// storage, one set of arrays per way
	////////////////////////////////////////

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_array #(.S_INDEX(S_INDEX), .payload_t(line_t)) i_data (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (cif.load_data[w]),
			.read    (cif.read_data),
			.rindex  (index),
			.windex  (index),
			.datain  (line_in),
			.dataout (data_out[w])
		);

		cache_array #(.S_INDEX(S_INDEX), .payload_t(logic [S_TAG-1:0])) i_tag (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (cif.load_tag[w]),
			.read    (cif.read_data),
			.rindex  (index),
			.windex  (index),
			.datain  (tag_in),
			.dataout (tag_out[w])
		);

		cache_array #(.S_INDEX(S_INDEX), .payload_t(logic)) i_valid (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (cif.set_valid[w]),
			.read    (cif.read_data),
			.rindex  (index),
			.windex  (index),
			.datain  (1'b1),
			.dataout (valid_out[w])
		);

		// dirty is read every cycle.
		cache_array #(.S_INDEX(S_INDEX), .payload_t(logic)) i_dirty (
			.clk     (clk),
			.arst_n  (arst_n),
			.load    (cif.set_dirty[w] | cif.clear_dirty[w]),
			.read    (1'b1),
			.rindex  (index),
			.windex  (index),
			.datain  (cif.set_dirty[w]),
			.dataout (dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == tag_in);
	end

	cache_array #(.S_INDEX(S_INDEX), .payload_t(logic)) i_lru (
		.clk     (clk),
		.arst_n  (arst_n),
		.load    (cif.load_lru),
		.read    (1'b1),
		.rindex  (index),
		.windex  (index),
		.datain  (lru_in),
		.dataout (cif.lru_out)
	);

	////////////////////////////////////////
	// status and output muxes
	////////////////////////////////////////

	assign cif.hit          = |way_hit;
	assign cif.way0_hit     = way_hit[0];
	assign cif.victim_dirty = dirty_out[cif.lru_out];
	assign pmem_wdata       = data_out[cif.lru_out]; // victim line.

	always_comb begin
		if (cif.hit) begin
			mem_rdata = way_hit[0] ? data_out[0] : data_out[1];
		end else begin
			mem_rdata = pmem_rdata;
		end

		unique case (cif.pmem_sel)
			mem_addr: pmem_address = {mem_address[ADDR_W-1:S_OFFSET], {S_OFFSET{1'b0}}};
			way0_wb:  pmem_address = {tag_out[0], index, {S_OFFSET{1'b0}}};
			way1_wb:  pmem_address = {tag_out[1], index, {S_OFFSET{1'b0}}};
			default:  pmem_address = mem_address;
		endcase
	end

	// a fill only writes the victim way, so a line lives in one way.
	a_one_way_hit: assert property (@(posedge clk) disable iff (!arst_n)
		!(way_hit[0] && way_hit[1]))
		else $error("l2_cache_datapath: both ways hit");

endmodule : l2_cache_datapath

`default_nettype wire

// ==== verilog/l2_cache_pkg.sv ====
`default_nettype none

package l2_cache_pkg;

	////////////////////////////////////////
	// geometry
	////////////////////////////////////////

	localparam int ADDR_W   = 32;  // byte address.
	localparam int LINE_W   = 256; // one 32-byte line.
	localparam int NUM_WAYS = 2;

	////////////////////////////////////////
	// payloads
	////////////////////////////////////////

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;

endpackage : l2_cache_pkg

`default_nettype wire

// ==== verilog/pmem_pkg.sv ====
`default_nettype none

package pmem_pkg;

	localparam int CREDIT_W = 2; // holds up to 3 credits.

	// source of the pmem address.
	typedef enum logic [1:0] {
		mem_addr = 2'b00, // fill of the requested line.
		way0_wb  = 2'b01, // victim in way 0.
		way1_wb  = 2'b10  // victim in way 1.
	} pmem_addr_sel_e;

endpackage : pmem_pkg

`default_nettype wire
